/* design/panel_pkg.sv */
// ==============================
// Shared types for the operator panel
// Main modes, error codes, error status struct
// Default timing constants
// ==============================

package panel_pkg;

    // Value equals the DIP code that selects the mode
    typedef enum logic [2:0] {
        MAIN_MENU     = 3'd0,
        MODE_INPUT    = 3'd1,
        MODE_GENERATE = 3'd2,
        MODE_DISPLAY  = 3'd3,
        MODE_COMPUTE  = 3'd4,
        MODE_SETTING  = 3'd5
    } main_mode_e;

    // Error codes reported by the mode engines
    typedef enum logic [3:0] {
        ERR_NONE         = 4'd0,
        ERR_DIM_RANGE    = 4'd1,
        ERR_VALUE_RANGE  = 4'd2,
        ERR_NO_MATRIX    = 4'd3,
        ERR_OP_MISMATCH  = 4'd4,
        ERR_STORAGE_FULL = 4'd5,
        ERR_BAD_FORMAT   = 4'd6,
        ERR_INTERNAL     = 4'd15
    } err_code_e;

    typedef struct packed {
        logic       active;     // Error LED
        logic [3:0] countdown;  // Digit 0 to 7
        err_code_e  code;
    } err_status_t;

    localparam logic [3:0]  COUNTDOWN_START          = 4'd7;
    localparam logic [31:0] DEFAULT_TICKS_PER_SECOND = 32'd100_000_000;
    localparam logic [31:0] DEFAULT_DEBOUNCE_CYCLES  = 32'd1_000_000;

endpackage

/* design/button_debounce.sv */
// ==============================
// Push button debouncer
// Two-flop sync, stability counter, press pulse
// ==============================

`timescale 1ns/1ps

module button_debounce #(
    parameter logic [31:0] debounce_cycles = panel_pkg::DEFAULT_DEBOUNCE_CYCLES
) (
    input  logic clk,
    input  logic rst_n,
    input  logic btn_in,
    output logic btn_pulse
);

    logic [1:0]  sync_q;
    logic        btn_sync;
    logic        btn_last;    // Previous synchronized sample
    logic [31:0] stable_cnt;
    logic        db_level;
    logic        db_level_q;

    assign btn_sync = sync_q[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q     <= 2'b00;
            btn_last   <= 1'b0;
            stable_cnt <= '0;
            db_level   <= 1'b0;
            db_level_q <= 1'b0;
        end else begin
            sync_q   <= {sync_q[0], btn_in};
            btn_last <= btn_sync;
            if (btn_sync != btn_last) begin
                stable_cnt <= '0;                    // Level moved, start over
            end else if (stable_cnt < debounce_cycles) begin
                stable_cnt <= stable_cnt + 32'd1;
            end
            // Accept the level only once it has held long enough
            if (stable_cnt == debounce_cycles) begin
                db_level <= btn_last;
            end
            db_level_q <= db_level;
        end
    end

    assign btn_pulse = db_level & ~db_level_q;   // Rising edge of debounced level

endmodule

/* design/mode_fsm.sv */
// ==============================
// Main menu state machine
// ==============================

`timescale 1ns/1ps

module mode_fsm (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [2:0]             dip_sw,
    input  logic                   confirm_pulse,
    input  logic                   back_pulse,
    output panel_pkg::main_mode_e  mode
);

    panel_pkg::main_mode_e state_q;
    panel_pkg::main_mode_e state_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= panel_pkg::MAIN_MENU;
        end else begin
            state_q <= state_d;
        end
    end

    // ==============================
    // Next state
    // ==============================
    always_comb begin
        state_d = state_q;
        if (state_q == panel_pkg::MAIN_MENU) begin
            if (confirm_pulse) begin
                case (dip_sw)
                    3'd1: state_d = panel_pkg::MODE_INPUT;
                    3'd2: state_d = panel_pkg::MODE_GENERATE;
                    3'd3: state_d = panel_pkg::MODE_DISPLAY;
                    3'd4: state_d = panel_pkg::MODE_COMPUTE;
                    3'd5: state_d = panel_pkg::MODE_SETTING;
                    default: state_d = panel_pkg::MAIN_MENU;  // Unused codes
                endcase
            end
        end else if (back_pulse) begin
            state_d = panel_pkg::MAIN_MENU;   // Confirm ignored inside a mode
        end
    end

    assign mode = state_q;

endmodule

/* design/error_countdown.sv */
// ==============================
// Error hold timer
// Countdown digit 7 to 1, timeout pulse on wrap
// ==============================

`timescale 1ns/1ps

module error_countdown #(
    parameter logic [31:0] ticks_per_second = panel_pkg::DEFAULT_TICKS_PER_SECOND
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  panel_pkg::main_mode_e   mode,
    input  panel_pkg::err_code_e    error_code,
    output panel_pkg::err_status_t  status,
    output logic                    error_timeout
);

    panel_pkg::err_code_e   eff_err;
    panel_pkg::err_status_t status_q;
    logic [31:0]            tick_cnt;
    logic [2:0]             sec_cnt;     // Whole seconds elapsed, 7 means wrap
    logic                   sec_done;

    // Errors only count while a mode is active
    assign eff_err  = (mode == panel_pkg::MAIN_MENU) ? panel_pkg::ERR_NONE : error_code;
    assign sec_done = (tick_cnt == ticks_per_second - 32'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt           <= '0;
            sec_cnt            <= 3'd0;
            status_q.active    <= 1'b0;
            status_q.countdown <= panel_pkg::COUNTDOWN_START;
            status_q.code      <= panel_pkg::ERR_NONE;
            error_timeout      <= 1'b0;
        end else begin
            status_q.code <= eff_err;
            if (eff_err == panel_pkg::ERR_NONE) begin
                tick_cnt           <= '0;
                sec_cnt            <= 3'd0;
                status_q.active    <= 1'b0;
                status_q.countdown <= panel_pkg::COUNTDOWN_START;
                error_timeout      <= 1'b0;
            end else if (sec_cnt == 3'd7) begin
                // Seven seconds held, restart the sequence
                tick_cnt           <= '0;
                sec_cnt            <= 3'd0;
                status_q.active    <= 1'b0;
                status_q.countdown <= 4'd0;
                error_timeout      <= 1'b1;
            end else begin
                if (sec_done) begin
                    tick_cnt <= '0;
                    sec_cnt  <= sec_cnt + 3'd1;
                end else begin
                    tick_cnt <= tick_cnt + 32'd1;
                end
                status_q.active    <= 1'b1;
                status_q.countdown <= panel_pkg::COUNTDOWN_START - {1'b0, sec_cnt};
                error_timeout      <= 1'b0;
            end
        end
    end

    assign status = status_q;

endmodule

/* design/segment_display.sv */
// ==============================
// Seven-segment encoder and status LEDs
// All outputs registered
// ==============================

`timescale 1ns/1ps

module segment_display (
    input  logic                    clk,
    input  logic                    rst_n,
    input  panel_pkg::main_mode_e   mode,
    input  panel_pkg::err_status_t  status,
    output logic [6:0]              seg_display,
    output logic [6:0]              seg_countdown,
    output logic [3:0]              led_status
);

    // Bit 0 is segment a, bit 6 is segment g
    localparam logic [6:0] SEG_E     = 7'h79;
    localparam logic [6:0] SEG_BLANK = 7'h00;

    logic [6:0] mode_seg;
    logic [6:0] count_seg;

    // ==============================
    // Digit table
    // ==============================
    function automatic logic [6:0] seg_digit(input logic [3:0] digit);
        logic [6:0] pattern;
        case (digit)
            4'd0:    pattern = 7'h3F;
            4'd1:    pattern = 7'h06;
            4'd2:    pattern = 7'h5B;
            4'd3:    pattern = 7'h4F;
            4'd4:    pattern = 7'h66;
            4'd5:    pattern = 7'h6D;
            4'd6:    pattern = 7'h7D;
            4'd7:    pattern = 7'h07;
            default: pattern = SEG_BLANK;  // Never shown by this panel
        endcase
        return pattern;
    endfunction

    assign mode_seg  = seg_digit({1'b0, mode});
    assign count_seg = seg_digit(status.countdown);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seg_display   <= seg_digit(4'd0);   // Menu digit
            seg_countdown <= SEG_BLANK;
            led_status    <= 4'd0;
        end else begin
            if (status.active) begin
                seg_display   <= SEG_E;
                seg_countdown <= count_seg;
            end else begin
                seg_display   <= mode_seg;
                seg_countdown <= SEG_BLANK;
            end
            led_status <= {status.active, mode};   // Error LED over mode number
        end
    end

endmodule

/* design/calc_panel_top.sv */
// ==============================
// Operator panel top level
// Debouncers, mode FSM, error timer, display
// ==============================

`timescale 1ns/1ps

module calc_panel_top #(
    parameter logic [31:0] ticks_per_second = panel_pkg::DEFAULT_TICKS_PER_SECOND,
    parameter logic [31:0] debounce_cycles  = panel_pkg::DEFAULT_DEBOUNCE_CYCLES
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  btn_confirm,
    input  logic                  btn_back,
    input  logic [2:0]            dip_sw,
    input  panel_pkg::err_code_e  error_code,   // From the external mode engines
    output logic [6:0]            seg_display,
    output logic [6:0]            seg_countdown,
    output logic [3:0]            led_status,
    output logic                  error_timeout
);

    logic                   confirm_pulse;
    logic                   back_pulse;
    panel_pkg::main_mode_e  mode;
    panel_pkg::err_status_t status;

    // ==============================
    // Button inputs
    // ==============================
    button_debounce #(
        .debounce_cycles(debounce_cycles)
    ) u_db_confirm (
        .clk       (clk),
        .rst_n     (rst_n),
        .btn_in    (btn_confirm),
        .btn_pulse (confirm_pulse)
    );

    button_debounce #(
        .debounce_cycles(debounce_cycles)
    ) u_db_back (
        .clk       (clk),
        .rst_n     (rst_n),
        .btn_in    (btn_back),
        .btn_pulse (back_pulse)
    );

    mode_fsm u_mode_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .dip_sw        (dip_sw),
        .confirm_pulse (confirm_pulse),
        .back_pulse    (back_pulse),
        .mode          (mode)
    );

    error_countdown #(
        .ticks_per_second(ticks_per_second)
    ) u_error_countdown (
        .clk           (clk),
        .rst_n         (rst_n),
        .mode          (mode),
        .error_code    (error_code),
        .status        (status),
        .error_timeout (error_timeout)
    );

    segment_display u_segment_display (
        .clk           (clk),
        .rst_n         (rst_n),
        .mode          (mode),
        .status        (status),
        .seg_display   (seg_display),
        .seg_countdown (seg_countdown),
        .led_status    (led_status)
    );

endmodule

/* testbench/tb_calc_panel.sv */
// ==============================
// Testbench for the operator panel
// Directed tests for menu, modes and error countdown
// ==============================

`timescale 1ns/1ps

module tb_calc_panel;

    localparam int TICKS = 20;    // Clock cycles per countdown second

    logic                 clk;
    logic                 rst_n;
    logic                 btn_confirm;
    logic                 btn_back;
    logic [2:0]           dip_sw;
    panel_pkg::err_code_e error_code;
    logic [6:0]           seg_display;
    logic [6:0]           seg_countdown;
    logic [3:0]           led_status;
    logic                 error_timeout;
    int                   errors;
    int                   test_errors_start;
    int                   tests_passed;
    int                   tests_failed;

    calc_panel_top #(
        .ticks_per_second(32'(TICKS)),
        .debounce_cycles (32'd4)
    ) DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .btn_confirm   (btn_confirm),
        .btn_back      (btn_back),
        .dip_sw        (dip_sw),
        .error_code    (error_code),
        .seg_display   (seg_display),
        .seg_countdown (seg_countdown),
        .led_status    (led_status),
        .error_timeout (error_timeout)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Common hex seven-segment patterns, bit 0 is segment a
    function automatic logic [6:0] digit_pattern(input logic [2:0] digit);
        logic [6:0] pattern;
        case (digit)
            3'd0:    pattern = 7'h3F;
            3'd1:    pattern = 7'h06;
            3'd2:    pattern = 7'h5B;
            3'd3:    pattern = 7'h4F;
            3'd4:    pattern = 7'h66;
            3'd5:    pattern = 7'h6D;
            3'd6:    pattern = 7'h7D;
            default: pattern = 7'h07;
        endcase
        return pattern;
    endfunction

    function automatic panel_pkg::err_code_e random_error();
        panel_pkg::err_code_e code;
        case ($urandom % 7)
            0:       code = panel_pkg::ERR_DIM_RANGE;
            1:       code = panel_pkg::ERR_VALUE_RANGE;
            2:       code = panel_pkg::ERR_NO_MATRIX;
            3:       code = panel_pkg::ERR_OP_MISMATCH;
            4:       code = panel_pkg::ERR_STORAGE_FULL;
            5:       code = panel_pkg::ERR_BAD_FORMAT;
            default: code = panel_pkg::ERR_INTERNAL;
        endcase
        return code;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == test_errors_start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - test_errors_start);
        end
        test_errors_start = errors;
    endtask

    // ==============================
    // Stimulus and wait helpers
    // ==============================
    task automatic press_button(input logic back);
        @(posedge clk);
        btn_back    <= back;
        btn_confirm <= !back;
        repeat (12) @(posedge clk);
        btn_back    <= 1'b0;
        btn_confirm <= 1'b0;
        repeat (12) @(posedge clk);
    endtask

    task automatic wait_panel(input logic [6:0] disp, input logic [6:0] count,
                              input logic [3:0] leds, input int limit, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!(seg_display == disp && seg_countdown == count && led_status == leds)
               && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!(seg_display == disp && seg_countdown == count && led_status == leds)) begin
            $display("Timed out after %0d cycles waiting for %s", limit, what);
            errors++;
        end
    endtask

    task automatic check_menu();
        check_value("led_status", 32'(led_status), 32'h0);
        check_value("seg_display", 32'(seg_display), 32'h3F);
        check_value("seg_countdown", 32'(seg_countdown), 32'h00);
        check_value("error_timeout", 32'(error_timeout), 32'h0);
    endtask

    task automatic enter_mode(input logic [2:0] m);
        @(posedge clk);
        dip_sw <= m;
        press_button(1'b0);
        wait_panel(digit_pattern(m), 7'h00, {1'b0, m}, 40, "mode entry");
    endtask

    task automatic leave_mode();
        press_button(1'b1);
        wait_panel(7'h3F, 7'h00, 4'h0, 40, "return to menu");
    endtask

    // ==============================
    // Directed tests
    // ==============================
    task automatic test_reset();
        repeat (30) begin
            @(negedge clk);
            check_menu();
        end
        finish_test("reset");
    endtask

    task automatic test_modes();
        for (int m = 1; m <= 5; m++) begin
            enter_mode(3'(m));
            @(posedge clk);
            dip_sw <= 3'((m + $urandom % 4) % 5 + 1);   // Another valid mode code
            press_button(1'b0);   // Confirm inside a mode, no effect
            @(negedge clk);
            check_value("led_status", 32'(led_status), 32'(m));
            check_value("seg_display", 32'(seg_display), 32'(digit_pattern(3'(m))));
            leave_mode();
        end
        finish_test("mode select");
    endtask

    task automatic test_bad_dip();
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            dip_sw <= (i == 0) ? 3'd0 : 3'(i + 5);
            press_button(1'b0);
            @(negedge clk);
            check_menu();
        end
        finish_test("unused dip codes");
    endtask

    task automatic test_menu_error();
        @(posedge clk);
        error_code <= random_error();
        repeat (3 * TICKS) begin
            @(negedge clk);
            check_menu();
        end
        @(posedge clk);
        error_code <= panel_pkg::ERR_NONE;
        finish_test("error masked in menu");
    endtask

    task automatic test_countdown();
        logic [2:0] m;
        logic [6:0] prev;
        logic [6:0] exp_seg;
        logic [6:0] seen [$];
        int         hold;
        int         cycles;
        int         pulses;
        logic       expect_blank;
        m = 3'(1 + $urandom % 5);
        enter_mode(m);
        @(posedge clk);
        error_code <= random_error();
        wait_panel(7'h79, digit_pattern(3'd7), {1'b1, m}, 10, "error display");
        prev = seg_countdown;
        seen.push_back(prev);
        hold = 1;
        cycles = 0;
        pulses = 0;
        expect_blank = 1'b0;
        while (seen.size() < 9 && cycles < 9 * TICKS) begin
            @(negedge clk);
            cycles++;
            // Display lags the timer by one register
            if (expect_blank) begin
                check_value("seg_countdown", 32'(seg_countdown), 32'h00);
            end
            expect_blank = error_timeout;
            if (error_timeout) begin
                pulses++;
            end
            if (seg_countdown == 7'h00) begin
                check_value("seg_display", 32'(seg_display), 32'(digit_pattern(m)));
                check_value("led_status", 32'(led_status), 32'({1'b0, m}));
            end else begin
                check_value("seg_display", 32'(seg_display), 32'h79);
                check_value("led_status", 32'(led_status), 32'({1'b1, m}));
            end
            if (seg_countdown != prev) begin
                // One second per digit, one cycle for the wrap state
                check_value("digit hold cycles", 32'(hold),
                            (seen.size() == 8) ? 32'd1 : 32'(TICKS));
                prev = seg_countdown;
                seen.push_back(prev);
                hold = 1;
            end else begin
                hold++;
            end
        end
        if (seen.size() < 9) begin
            $display("Countdown did not restart within %0d cycles", 9 * TICKS);
            errors++;
        end
        for (int i = 0; i < seen.size(); i++) begin
            exp_seg = (i == 7) ? 7'h00
                    : (i == 8) ? digit_pattern(3'd7)
                    : digit_pattern(3'(7 - i));
            check_value("seg_countdown step", 32'(seen[i]), 32'(exp_seg));
        end
        check_value("error_timeout pulses", 32'(pulses), 32'd1);
        @(posedge clk);
        error_code <= panel_pkg::ERR_NONE;
        leave_mode();
        finish_test("error countdown");
    endtask

    task automatic test_clear_error();
        logic [2:0] m;
        m = 3'(1 + $urandom % 5);
        enter_mode(m);
        @(posedge clk);
        error_code <= random_error();
        wait_panel(7'h79, digit_pattern(3'd4), {1'b1, m}, 5 * TICKS, "countdown digit 4");
        @(posedge clk);
        error_code <= panel_pkg::ERR_NONE;
        wait_panel(digit_pattern(m), 7'h00, {1'b0, m}, 5, "error display to clear");
        leave_mode();
        finish_test("error cleared");
    endtask

    initial begin
        rst_n             = 1'b0;
        btn_confirm       = 1'b0;
        btn_back          = 1'b0;
        dip_sw            = 3'd0;
        error_code        = panel_pkg::ERR_NONE;
        errors            = 0;
        test_errors_start = 0;
        tests_passed      = 0;
        tests_failed      = 0;
        void'($urandom(32'h5499_f8b7));
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_modes();
        test_bad_dip();
        test_menu_error();
        test_countdown();
        test_clear_error();
        $display("Tests passed: %0d, tests failed: %0d, failed checks: %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Overall cycle limit for the run
    initial begin
        repeat (20000) @(posedge clk);
        $display("Simulation ran past its cycle limit");
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* filelist.f */
design/panel_pkg.sv
design/button_debounce.sv
design/mode_fsm.sv
design/error_countdown.sv
design/segment_display.sv
design/calc_panel_top.sv
testbench/tb_calc_panel.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the panel testbench with Verilator
rm -f sim.log
verilator --binary --timing --top-module tb_calc_panel -f filelist.f -o sim_calc_panel \
    && ./obj_dir/sim_calc_panel > sim.log 2>&1 \
    || { echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0
